//--- rtl/cd_rx_consts.svh
//==========================================================================
// CDBUS receive path constants
// Buffer geometry, largest user data length and CRC-16 parameters
//==========================================================================

`ifndef CD_RX_CONSTS_SVH
`define CD_RX_CONSTS_SVH

// index table width, 2^6 = 64 blocks
`define CD_I_WIDTH 6

// buffer byte address width, 2^11 = 2048 bytes
`define CD_B_WIDTH 11

// largest user data length carried by one frame
`define CD_MAX_DLEN 253

// CRC-16/MODBUS style, bytes fed lsb first
`define CD_CRC_INIT 16'hFFFF
`define CD_CRC_POLY 16'hA001

`endif

//--- rtl/cd_frame_pkg.sv
//==========================================================================
// CDBUS frame types
// Parser states and the parser to buffer request formats
//==========================================================================

package cd_frame_pkg;

    typedef enum logic [2:0] {
        IDLE,   // waiting for src byte
        HDR,    // dst and len
        DATA,   // user data
        CRC,    // two trailing crc bytes
        DROP    // frame ran past the buffer limit
    } dec_state_t;

    // one byte for the frame buffer
    typedef struct packed {
        logic [7:0] data;
        logic [7:0] addr;   // byte offset inside the frame
        logic       en;
    } wr_req_t;

    // end of frame, switch is a single cycle pulse
    typedef struct packed {
        logic [7:0] len;
        logic       err;
        logic       switch;
    } commit_t;

endpackage

//--- rtl/cd_buf_pkg.sv
//==========================================================================
// CDBUS stored frame types
// Index table entry, reader states and the host byte format
//==========================================================================

package cd_buf_pkg;

    typedef struct packed {
        logic       err;
        logic [2:0] frag;   // extra 32-byte blocks used by the frame
        logic [7:0] len;    // user data length
    } idx_entry_t;

    typedef enum logic [1:0] {
        WAIT,
        FETCH,
        STREAM,
        DONE
    } rdr_state_t;

    typedef struct packed {
        logic [7:0] data;
        logic       valid;
        logic       first;  // src byte
        logic       last;   // final user data byte
        logic       err;    // held for the whole frame
        logic [7:0] len;    // held for the whole frame
    } host_out_t;

endpackage

//--- rtl/cd_sdpram.sv
//==========================================================================
// Simple dual-port RAM
// Registered read, one write port, active-low chip and write enables
//==========================================================================

module cd_sdpram #(
    parameter int A_WIDTH = 8,
    parameter int D_WIDTH = 8
) (
    input  logic               clk,
    input  logic               cen,
    input  logic [A_WIDTH-1:0] ra,
    input  logic [A_WIDTH-1:0] wa,
    input  logic [D_WIDTH-1:0] wd,
    input  logic               wen,
    output logic [D_WIDTH-1:0] rd
);

    logic [D_WIDTH-1:0] mem [0:2**A_WIDTH-1];

    always_ff @(posedge clk) begin
        if (!cen) begin
            rd <= mem[ra];      // old data on a same-address write
            if (!wen) begin
                mem[wa] <= wd;
            end
        end
    end

endmodule

//--- rtl/cd_rx_decode.sv
//==========================================================================
// CDBUS frame parser
// Checks CRC-16 and byte count, forwards header and data to the buffer
//==========================================================================

`include "cd_rx_consts.svh"

module cd_rx_decode (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic [7:0]            in_byte,
    input  logic                  in_valid,
    input  logic                  in_end,
    output cd_frame_pkg::wr_req_t wr_req,
    output cd_frame_pkg::commit_t commit
);

    cd_frame_pkg::dec_state_t state;
    logic [8:0]               cnt;      // offset of the incoming byte
    logic [7:0]               len;
    logic [15:0]              crc;
    logic [15:0]              rx_crc;   // received low byte first
    logic [8:0]               data_end;

    // reflected crc over one byte
    function automatic logic [15:0] crc_step(input logic [15:0] c_in, input logic [7:0] b);
        logic [15:0] c;
        int          i;
        c = c_in ^ {8'h00, b};
        for (i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ `CD_CRC_POLY) : (c >> 1);
        end
        return c;
    endfunction

    assign data_end = {1'b0, len} + 9'd2;   // offset of the last data byte

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state  <= cd_frame_pkg::IDLE;
            cnt    <= '0;
            len    <= '0;
            crc    <= `CD_CRC_INIT;
            rx_crc <= '0;
            wr_req <= '0;
            commit <= '0;
        end else begin
            wr_req.en     <= 1'b0;
            commit.switch <= 1'b0;
            if (in_end) begin
                if (state != cd_frame_pkg::IDLE) begin
                    commit.switch <= 1'b1;
                    commit.len    <= len;
                    commit.err    <= (state == cd_frame_pkg::DROP) || (crc != rx_crc) ||
                                     (cnt != {1'b0, len} + 9'd5) || (len > `CD_MAX_DLEN);
                end
                state <= cd_frame_pkg::IDLE;
                cnt   <= '0;
                len   <= '0;
                crc   <= `CD_CRC_INIT;
            end else if (in_valid) begin
                if (cnt != '1) begin
                    cnt <= cnt + 9'd1;  // saturates on runaway frames
                end
                wr_req.data <= in_byte;
                wr_req.addr <= cnt[7:0];
                case (state)
                    cd_frame_pkg::IDLE: begin
                        wr_req.en <= 1'b1;
                        crc       <= crc_step(crc, in_byte);
                        state     <= cd_frame_pkg::HDR;
                    end
                    cd_frame_pkg::HDR: begin
                        wr_req.en <= 1'b1;
                        crc       <= crc_step(crc, in_byte);
                        if (cnt == 9'd2) begin
                            len   <= in_byte;
                            state <= (in_byte == 8'd0) ? cd_frame_pkg::CRC : cd_frame_pkg::DATA;
                        end
                    end
                    cd_frame_pkg::DATA: begin
                        wr_req.en <= 1'b1;
                        crc       <= crc_step(crc, in_byte);
                        if (cnt == data_end) begin
                            state <= cd_frame_pkg::CRC;
                        end else if (cnt == 9'd255) begin
                            state <= cd_frame_pkg::DROP;    // no room past offset 255
                        end
                    end
                    cd_frame_pkg::CRC: begin
                        if (cnt == data_end + 9'd1) begin
                            rx_crc[7:0] <= in_byte;
                        end else if (cnt == data_end + 9'd2) begin
                            rx_crc[15:8] <= in_byte;
                        end
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

//--- rtl/cd_rx_ram.sv
//==========================================================================
// CDBUS receive frame buffer
// Ring of 32-byte blocks plus an index table, one dirty bit per block
//==========================================================================

`include "cd_rx_consts.svh"

module cd_rx_ram #(
    parameter int I_WIDTH = `CD_I_WIDTH,
    parameter int B_WIDTH = `CD_B_WIDTH
) (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic [5:0]            rd_addr,      // word index inside the frame
    input  logic                  rd_en,
    input  logic                  rd_done,
    input  logic                  rd_done_all,
    input  cd_frame_pkg::wr_req_t wr_req,
    input  cd_frame_pkg::commit_t commit,
    output logic [31:0]           rd_word,
    output logic                  unread,
    output logic [7:0]            rd_len,
    output logic                  rd_err,
    output logic                  switch_fail
);

    localparam int S_WIDTH = B_WIDTH - I_WIDTH;     // block size, 2^5 bytes
    localparam int F_WIDTH = 8 - S_WIDTH;           // blocks per 256-byte frame

    logic [I_WIDTH-1:0]     wr_sel;                 // first block of the incoming frame
    logic [I_WIDTH-1:0]     rd_sel;                 // first block of the oldest frame
    logic [2**I_WIDTH-1:0]  dirty;
    logic [I_WIDTH-1:0]     wr_blk;
    logic [B_WIDTH-1:0]     buf_wr_addr;
    logic [B_WIDTH-1:0]     buf_rd_addr;
    logic [31:0]            wr_word;
    logic                   wr_en_d;
    logic                   wr_cancel;
    logic [F_WIDTH-1:0]     wr_frag;
    logic                   idx_wr_en;
    cd_buf_pkg::idx_entry_t idx_wr;
    cd_buf_pkg::idx_entry_t idx_rd;

    assign wr_blk      = wr_sel + I_WIDTH'(wr_req.addr[7:S_WIDTH]);
    assign buf_rd_addr = {rd_sel, {S_WIDTH{1'b0}}} + B_WIDTH'({rd_addr, 2'b00});
    assign idx_wr_en   = commit.switch & ~wr_cancel;
    assign idx_wr      = '{err: commit.err, frag: wr_frag, len: commit.len};
    assign rd_len      = idx_rd.len;
    assign rd_err      = idx_rd.err;

    // byte lanes fill in order, the word is rewritten after every byte
    always_ff @(posedge clk) begin
        buf_wr_addr <= {wr_sel, {S_WIDTH{1'b0}}} + B_WIDTH'(wr_req.addr);
        if (wr_req.en) begin
            wr_word[8*wr_req.addr[1:0] +: 8] <= wr_req.data;
        end
    end

    cd_sdpram #(.A_WIDTH(B_WIDTH-2), .D_WIDTH(32)) u_data_buf (
        .clk (clk),
        .cen (~(rd_en | wr_en_d)),
        .ra  (buf_rd_addr[B_WIDTH-1:2]),
        .wa  (buf_wr_addr[B_WIDTH-1:2]),
        .wd  (wr_word),
        .wen (~wr_en_d),
        .rd  (rd_word)
    );

    cd_sdpram #(.A_WIDTH(I_WIDTH), .D_WIDTH($bits(cd_buf_pkg::idx_entry_t))) u_idx_table (
        .clk (clk),
        .cen (1'b0),        // entry of rd_sel is always being read
        .ra  (rd_sel),
        .wa  (wr_sel),
        .wd  (idx_wr),
        .wen (~idx_wr_en),
        .rd  (idx_rd)
    );

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_sel      <= '0;
            rd_sel      <= '0;
            dirty       <= '0;
            wr_en_d     <= 1'b0;
            wr_cancel   <= 1'b0;
            wr_frag     <= '0;
            switch_fail <= 1'b0;
            unread      <= 1'b0;
        end else begin
            switch_fail <= 1'b0;
            wr_en_d     <= 1'b0;
            unread      <= dirty[rd_sel] & ~rd_done & ~rd_done_all;

            // frames are contiguous, so the oldest frame's first block is hit first
            if (wr_req.en && !wr_cancel) begin
                if (dirty[wr_blk]) begin
                    wr_cancel <= 1'b1;
                end else begin
                    wr_en_d <= 1'b1;
                    wr_frag <= wr_req.addr[7:S_WIDTH];
                end
            end

            if (commit.switch) begin
                if (wr_cancel) begin
                    switch_fail <= 1'b1;
                end else begin
                    dirty[wr_sel] <= 1'b1;
                    wr_sel        <= wr_sel + I_WIDTH'(wr_frag) + 1'b1;
                end
                wr_cancel <= 1'b0;
            end

            if (rd_done && dirty[rd_sel]) begin
                dirty[rd_sel] <= 1'b0;
                rd_sel        <= rd_sel + I_WIDTH'(idx_rd.frag) + 1'b1;
            end

            if (rd_done_all) begin
                wr_sel      <= '0;
                rd_sel      <= '0;
                dirty       <= '0;
                wr_cancel   <= 1'b0;
                switch_fail <= 1'b0;
            end
        end
    end

endmodule

//--- rtl/cd_rx_reader.sv
//==========================================================================
// CDBUS frame reader
// Streams each stored frame to the host one byte per cycle, then frees it
//==========================================================================

module cd_rx_reader (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic [31:0]           rd_word,
    input  logic                  unread,
    input  logic [7:0]            rd_len,
    input  logic                  rd_err,
    input  logic                  rx_hold,
    input  logic                  flush,
    output logic [5:0]            rd_addr,
    output logic                  rd_en,
    output logic                  rd_done,
    output cd_buf_pkg::host_out_t host_out
);

    cd_buf_pkg::rdr_state_t state;
    logic [8:0]             cnt;        // index of the byte being emitted
    logic [8:0]             last_idx;
    logic [31:0]            cur;
    logic [31:0]            word;

    assign last_idx = {1'b0, host_out.len} + 9'd2;
    // lane 0 comes straight from the ram, the rest from the held word
    assign word     = (cnt[1:0] == 2'd0) ? rd_word : cur;

    always_ff @(posedge clk) begin
        if (state == cd_buf_pkg::STREAM && cnt[1:0] == 2'd0) begin
            cur <= rd_word;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state    <= cd_buf_pkg::WAIT;
            cnt      <= '0;
            rd_addr  <= '0;
            rd_en    <= 1'b0;
            rd_done  <= 1'b0;
            host_out <= '0;
        end else begin
            rd_en          <= 1'b0;
            rd_done        <= 1'b0;
            host_out.valid <= 1'b0;
            host_out.first <= 1'b0;
            host_out.last  <= 1'b0;
            if (flush) begin
                state <= cd_buf_pkg::WAIT;
            end else begin
                case (state)
                    cd_buf_pkg::WAIT: begin
                        // unread is stale in the cycle of our own rd_done
                        if (unread && !rx_hold && !rd_done) begin
                            rd_en        <= 1'b1;
                            rd_addr      <= '0;
                            cnt          <= '0;
                            host_out.len <= rd_len;
                            host_out.err <= rd_err;
                            state        <= cd_buf_pkg::FETCH;
                        end
                    end
                    cd_buf_pkg::FETCH: begin
                        state <= cd_buf_pkg::STREAM;    // word 0 arrives next cycle
                    end
                    cd_buf_pkg::STREAM: begin
                        host_out.valid <= 1'b1;
                        host_out.first <= (cnt == 9'd0);
                        host_out.data  <= word[8*cnt[1:0] +: 8];
                        if (cnt[1:0] == 2'd2) begin
                            rd_en   <= 1'b1;            // prefetch the next word
                            rd_addr <= rd_addr + 6'd1;
                        end
                        if (cnt == last_idx) begin
                            host_out.last <= 1'b1;
                            state         <= cd_buf_pkg::DONE;
                        end
                        cnt <= cnt + 9'd1;
                    end
                    default: begin
                        rd_done <= 1'b1;
                        state   <= cd_buf_pkg::WAIT;
                    end
                endcase
            end
        end
    end

endmodule

//--- rtl/cd_rx_top.sv
//==========================================================================
// CDBUS receive subsystem
// Frame parser, block-ring buffer and host reader
//==========================================================================

module cd_rx_top (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic [7:0]            in_byte,
    input  logic                  in_valid,
    input  logic                  in_end,
    input  logic                  rx_hold,
    input  logic                  flush,
    output cd_buf_pkg::host_out_t host_out,
    output logic                  overflow
);

    cd_frame_pkg::wr_req_t wr_req;
    cd_frame_pkg::commit_t commit;
    logic [31:0]           rd_word;
    logic [5:0]            rd_addr;
    logic                  rd_en;
    logic                  rd_done;
    logic                  unread;
    logic [7:0]            rd_len;
    logic                  rd_err;

    cd_rx_decode u_decode (
        .clk      (clk),
        .reset_n  (reset_n),
        .in_byte  (in_byte),
        .in_valid (in_valid),
        .in_end   (in_end),
        .wr_req   (wr_req),
        .commit   (commit)
    );

    cd_rx_ram u_ram (
        .clk         (clk),
        .reset_n     (reset_n),
        .rd_addr     (rd_addr),
        .rd_en       (rd_en),
        .rd_done     (rd_done),
        .rd_done_all (flush),
        .wr_req      (wr_req),
        .commit      (commit),
        .rd_word     (rd_word),
        .unread      (unread),
        .rd_len      (rd_len),
        .rd_err      (rd_err),
        .switch_fail (overflow)
    );

    cd_rx_reader u_reader (
        .clk      (clk),
        .reset_n  (reset_n),
        .rd_word  (rd_word),
        .unread   (unread),
        .rd_len   (rd_len),
        .rd_err   (rd_err),
        .rx_hold  (rx_hold),
        .flush    (flush),
        .rd_addr  (rd_addr),
        .rd_en    (rd_en),
        .rd_done  (rd_done),
        .host_out (host_out)
    );

endmodule

//--- tb/tb_cd_rx.sv
//==========================================================================
// CDBUS receive subsystem testbench
// Directed frames through parser, buffer and reader, checked at the host
//==========================================================================

`include "cd_rx_consts.svh"

module tb_cd_rx;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT = 2000;      // cycles allowed for any single wait

    logic                  clk;
    logic                  reset_n;
    logic [7:0]            in_byte;
    logic                  in_valid;
    logic                  in_end;
    logic                  rx_hold;
    logic                  flush;
    cd_buf_pkg::host_out_t host_out;
    logic                  overflow;

    cd_buf_pkg::host_out_t rx_q[$];     // host bytes in arrival order
    logic [7:0]            tx_q[$];     // wire bytes of the frame being built
    logic [7:0]            exp_bytes[$];
    int                    exp_len[$];
    logic                  exp_err[$];
    logic [31:0]           lcg_state = 32'h85dbc089;
    int                    ovf_count = 0;
    int                    errors = 0;
    int                    checks = 0;
    int                    tests_run = 0;
    int                    tests_failed = 0;

    initial clk = 1'b0;
    always #2 clk = ~clk;

    cd_rx_top dut0 (
        .clk      (clk),
        .reset_n  (reset_n),
        .in_byte  (in_byte),
        .in_valid (in_valid),
        .in_end   (in_end),
        .rx_hold  (rx_hold),
        .flush    (flush),
        .host_out (host_out),
        .overflow (overflow)
    );

    // host side never stalls, so every valid byte is captured here
    always @(posedge clk) begin
        if (host_out.valid) begin
            rx_q.push_back(host_out);
        end
        if (overflow) begin
            ovf_count++;
        end
    end

    function automatic logic [7:0] lcg_byte();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[23:16];
    endfunction

    // reflected CRC-16 over every byte now in tx_q, lsb first
    function automatic logic [15:0] ref_crc();
        logic [15:0] c;
        logic        fb;
        int          i;
        int          k;
        c = `CD_CRC_INIT;
        for (i = 0; i < tx_q.size(); i++) begin
            for (k = 0; k < 8; k++) begin
                fb = c[0] ^ tx_q[i][k];
                c  = {1'b0, c[15:1]};
                if (fb) begin
                    c = c ^ `CD_CRC_POLY;
                end
            end
        end
        return c;
    endfunction

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
    endtask

    // src, dst, len, data (plus extra bytes), crc low then high
    task automatic build_frame(input int len, input int extra, input logic bad_crc);
        logic [15:0] crc;
        int          i;
        tx_q.delete();
        tx_q.push_back(lcg_byte());
        tx_q.push_back(lcg_byte());
        tx_q.push_back(len[7:0]);
        for (i = 0; i < len + extra; i++) begin
            tx_q.push_back(lcg_byte());
        end
        crc = ref_crc();
        tx_q.push_back(crc[7:0] ^ (bad_crc ? 8'h5a : 8'h00));
        tx_q.push_back(crc[15:8]);
    endtask

    // only header and len data bytes are stored and replayed
    task automatic expect_frame(input int len, input logic err);
        int i;
        for (i = 0; i < len + 3; i++) begin
            exp_bytes.push_back(tx_q[i]);
        end
        exp_len.push_back(len);
        exp_err.push_back(err);
    endtask

    task automatic send_frame();
        int i;
        for (i = 0; i < tx_q.size(); i++) begin
            @(posedge clk);
            in_byte  <= tx_q[i];
            in_valid <= 1'b1;
        end
        @(posedge clk);
        in_valid <= 1'b0;
        in_end   <= 1'b1;           // idle gap marker
        @(posedge clk);
        in_end <= 1'b0;
        idle(4);
    endtask

    task automatic check_byte(input cd_buf_pkg::host_out_t got,
                              input cd_buf_pkg::host_out_t exp);
        checks++;
        if (got.data !== exp.data) begin
            $display("Fail host_out.data: got %h expected %h", got.data, exp.data);
            errors++;
        end
        if (got.first !== exp.first) begin
            $display("Fail host_out.first: got %h expected %h", got.first, exp.first);
            errors++;
        end
        if (got.last !== exp.last) begin
            $display("Fail host_out.last: got %h expected %h", got.last, exp.last);
            errors++;
        end
    endtask

    task automatic check_len_err(input cd_buf_pkg::host_out_t got,
                                 input cd_buf_pkg::idx_entry_t exp);
        checks++;
        if (got.len !== exp.len) begin
            $display("Fail host_out.len: got %h expected %h", got.len, exp.len);
            errors++;
        end
        if (got.err !== exp.err) begin
            $display("Fail host_out.err: got %h expected %h", got.err, exp.err);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            $display("Fail %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic wait_host_byte(output logic ok);
        int t;
        t = 0;
        while (rx_q.size() == 0 && t < TIMEOUT) begin
            @(posedge clk);
            t++;
        end
        ok = (rx_q.size() != 0);
    endtask

    // compares every expected frame against the captured host bytes
    task automatic drain_frames();
        cd_buf_pkg::host_out_t  got;
        cd_buf_pkg::host_out_t  exp;
        cd_buf_pkg::idx_entry_t ent;
        logic                   ok;
        int                     n;
        int                     i;
        while (exp_len.size() > 0) begin
            n       = exp_len.pop_front();
            ent     = '0;
            ent.len = n[7:0];
            ent.err = exp_err.pop_front();
            for (i = 0; i < n + 3; i++) begin
                wait_host_byte(ok);
                if (!ok) begin
                    $display("timeout: byte %0d of a frame with len %0d never reached the host",
                             i, n);
                    errors++;
                    exp_bytes.delete();
                    exp_len.delete();
                    exp_err.delete();
                    return;
                end
                got       = rx_q.pop_front();
                exp       = '0;
                exp.data  = exp_bytes.pop_front();
                exp.first = (i == 0);
                exp.last  = (i == n + 2);
                check_byte(got, exp);
                check_len_err(got, ent);
            end
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        tests_run++;
        if (errors != err_before) begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - err_before);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    task automatic single_frame();
        int e0;
        int o0;
        int len;
        e0  = errors;
        o0  = ovf_count;
        len = int'(lcg_byte()) % 64 + 1;
        build_frame(len, 0, 1'b0);
        expect_frame(len, 1'b0);
        send_frame();
        drain_frames();
        check_flag("overflow pulses", ovf_count - o0, 0);
        report_test("single_frame", e0);
    endtask

    // 0 and 29 fit one block, 30 spills into a second, 253 uses eight
    task automatic length_sweep();
        int lens [4];
        int e0;
        int o0;
        int i;
        e0   = errors;
        o0   = ovf_count;
        lens = '{0, 29, 30, 253};
        for (i = 0; i < 4; i++) begin
            build_frame(lens[i], 0, 1'b0);
            expect_frame(lens[i], 1'b0);
            send_frame();
        end
        drain_frames();
        check_flag("overflow pulses", ovf_count - o0, 0);
        report_test("length_sweep", e0);
    endtask

    task automatic error_flags();
        int e0;
        int o0;
        e0 = errors;
        o0 = ovf_count;
        build_frame(12, 0, 1'b1);       // bad crc low byte
        expect_frame(12, 1'b1);
        send_frame();
        build_frame(20, 1, 1'b0);       // one byte more than len says
        expect_frame(20, 1'b1);
        send_frame();
        drain_frames();
        check_flag("overflow pulses", ovf_count - o0, 0);
        report_test("error_flags", e0);
    endtask

    task automatic overflow_fill();
        int e0;
        int o0;
        int i;
        int t;
        e0 = errors;
        o0 = ovf_count;
        rx_hold <= 1'b1;
        for (i = 0; i < 8; i++) begin
            build_frame(253, 0, 1'b0);      // 256 stored bytes, 8 blocks
            expect_frame(253, 1'b0);
            send_frame();
        end
        check_flag("overflow pulses", ovf_count - o0, 0);
        build_frame(253, 0, 1'b0);
        send_frame();
        t = 0;
        while (ovf_count == o0 && t < TIMEOUT) begin
            @(posedge clk);
            t++;
        end
        idle(4);
        check_flag("overflow pulses", ovf_count - o0, 1);
        rx_hold <= 1'b0;
        drain_frames();
        idle(50);
        check_flag("host bytes after eighth frame", rx_q.size(), 0);
        report_test("overflow_fill", e0);
    endtask

    task automatic flush_buffer();
        int e0;
        int o0;
        int i;
        e0 = errors;
        o0 = ovf_count;
        rx_hold <= 1'b1;
        for (i = 0; i < 2; i++) begin
            build_frame(40, 0, 1'b0);
            send_frame();
        end
        idle(4);
        flush <= 1'b1;
        @(posedge clk);
        flush   <= 1'b0;
        rx_hold <= 1'b0;
        idle(50);
        check_flag("host bytes after flush", rx_q.size(), 0);
        build_frame(17, 0, 1'b0);
        expect_frame(17, 1'b0);
        send_frame();
        drain_frames();
        check_flag("overflow pulses", ovf_count - o0, 0);
        report_test("flush_buffer", e0);
    endtask

    initial begin
        reset_n  = 1'b0;
        in_byte  = 8'h00;
        in_valid = 1'b0;
        in_end   = 1'b0;
        rx_hold  = 1'b0;
        flush    = 1'b0;
        repeat (8) @(posedge clk);
        reset_n <= 1'b1;
        idle(4);
        single_frame();
        length_sweep();
        error_flags();
        overflow_fill();
        flush_buffer();
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- list.f
+incdir+rtl
rtl/cd_frame_pkg.sv
rtl/cd_buf_pkg.sv
rtl/cd_sdpram.sv
rtl/cd_rx_decode.sv
rtl/cd_rx_ram.sv
rtl/cd_rx_reader.sv
rtl/cd_rx_top.sv
tb/tb_cd_rx.sv

//--- run.sh
#!/usr/bin/env bash
# Build the CDBUS receive testbench with Verilator, run it, check the log.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --timescale 1ns/100ps -f list.f \
    --top-module tb_cd_rx -Mdir "$BUILD_DIR" -o tb_cd_rx
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$BUILD_DIR/tb_cd_rx" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TESTS PASSED$" "$LOG"; then
    exit 0
else
    echo "pass message not found in $LOG"
    exit 1
fi
